// ==== Bender.yml ====
package:
  name: dfi_seq

sources:
  - design/dfi_seq_pkg.sv
  - design/dfi_cmd_sched.sv
  - design/dfi_wr_fifo.sv
  - design/dfi_wr_serializer.sv
  - design/dfi_rd_assembler.sv
  - design/dfi_seq_top.sv
  - target: simulation
    files:
      - sim/tb_dfi_seq.sv

// ==== design/dfi_cmd_sched.sv ====
//----------------------------------------
// DFI command scheduler
// Checks DDR timing, drives command pins,
// makes write and read enable strobes
//----------------------------------------
`timescale 1ns/1ns

module dfi_cmd_sched
    import dfi_seq_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  ddr_cmd_t  command_i,
    input  ddr_addr_t address_i,
    input  ddr_bank_t bank_i,
    input  logic      cke_i,
    output logic      accept_o,
    output logic      wr_push_o,
    output logic      wr_en_o,
    output logic      dfi_rddata_en_o,
    output logic      dfi_cs_n_o,
    output logic      dfi_ras_n_o,
    output logic      dfi_cas_n_o,
    output logic      dfi_we_n_o,
    output ddr_addr_t dfi_address_o,
    output ddr_bank_t dfi_bank_o,
    output logic      dfi_cke_o
);

    logic [DELAY_W-1:0]    delay_q;
    logic [DELAY_W-1:0]    delay_d;
    ddr_cmd_t              last_cmd_q;
    logic [WR_SHIFT_W-1:0] wr_en_q;
    logic [RD_SHIFT_W-1:0] rd_en_q;
    logic                  rd_early_w;
    logic                  wr_early_w;
    ddr_cmd_t              command_q;
    ddr_addr_t             addr_q;
    ddr_bank_t             bank_q;
    logic                  cke_q;
    logic                  rd_en_q_r;

    //----------------------------------------
    // Accept
    //----------------------------------------
    // Same direction follow-up skips the rest of the turnaround
    assign rd_early_w = (last_cmd_q == CMD_READ) && (command_i == CMD_READ)
                        && (delay_q == RW_SEQ_CYCLES);
    assign wr_early_w = (last_cmd_q == CMD_WRITE) && (command_i == CMD_WRITE)
                        && (delay_q == RW_SEQ_CYCLES);

    assign accept_o  = (delay_q == '0) || rd_early_w || wr_early_w
                       || (command_i == CMD_NOP);
    assign wr_push_o = accept_o && (command_i == CMD_WRITE);

    // Last non-NOP command, for the early accept rule
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            last_cmd_q <= CMD_NOP;
        else if (accept_o && (command_i != CMD_NOP))
            last_cmd_q <= command_i;
    end

    //----------------------------------------
    // Delay counter
    //----------------------------------------
    always_comb
    begin
        delay_d = delay_q;
        if (delay_q == '0)
        begin
            // Load spacing for the command accepted now
            case (command_i)
                CMD_ACTIVE:                       delay_d = TRCD_CYCLES;
                CMD_READ, CMD_WRITE:              delay_d = RW_NONSEQ_CYCLES;
                CMD_PRECHARGE:                    delay_d = TRP_CYCLES;
                CMD_REFRESH:                      delay_d = TRFC_CYCLES;
                CMD_NOP, CMD_ZQCL, CMD_LOAD_MODE: delay_d = '0;
                default:                          delay_d = '0;
            endcase
        end
        else if (rd_early_w || wr_early_w)
            // Early accept restarts the full turnaround
            delay_d = RW_NONSEQ_CYCLES;
        else
            delay_d = delay_q - DELAY_W'(1);
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            delay_q <= '0;
        else
            delay_q <= delay_d;
    end

    //----------------------------------------
    // Write and read enable shifters
    //----------------------------------------
    // Burst of ones loaded PHY_WRLAT stages from the tap
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            wr_en_q <= '0;
        else if (wr_push_o)
            wr_en_q <= {{DDR_BURST_LEN{1'b1}}, wr_en_q[PHY_WRLAT:1]};
        else
            wr_en_q <= {1'b0, wr_en_q[WR_SHIFT_W-1:1]};
    end

    assign wr_en_o = wr_en_q[0];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            rd_en_q <= '0;
        else if (accept_o && (command_i == CMD_READ))
            rd_en_q <= {{DDR_BURST_LEN{1'b1}}, rd_en_q[PHY_RDLAT:1]};
        else
            rd_en_q <= {1'b0, rd_en_q[RD_SHIFT_W-1:1]};
    end

    // Output flop completes the read latency
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            rd_en_q_r <= 1'b0;
        else
            rd_en_q_r <= rd_en_q[0];
    end

    assign dfi_rddata_en_o = rd_en_q_r;

    //----------------------------------------
    // Drive flops
    //----------------------------------------
    // NOP and zeros whenever nothing is accepted
    always_ff @(posedge clk_i)
    begin
        if (rst_i || !accept_o)
        begin
            command_q <= CMD_NOP;
            addr_q    <= '0;
            bank_q    <= '0;
        end
        else
        begin
            command_q <= command_i;
            addr_q    <= address_i;
            bank_q    <= bank_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            cke_q <= 1'b0;
        else
            cke_q <= cke_i;
    end

    assign dfi_cs_n_o    = command_q[3];
    assign dfi_ras_n_o   = command_q[2];
    assign dfi_cas_n_o   = command_q[1];
    assign dfi_we_n_o    = command_q[0];
    assign dfi_address_o = addr_q;
    assign dfi_bank_o    = bank_q;
    assign dfi_cke_o     = cke_q;

endmodule

// ==== design/dfi_rd_assembler.sv ====
//----------------------------------------
// Read beat assembler
// Packs four DFI beats into one host line
//----------------------------------------
`timescale 1ns/1ns

module dfi_rd_assembler
    import dfi_seq_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  dfi_data_t  dfi_rddata_i,
    input  logic       dfi_rddata_valid_i,
    output line_data_t rddata_o,
    output logic       rddata_valid_o
);

    logic [BEAT_W-1:0] beat_idx_q;
    line_data_t        line_q;
    logic              valid_q;

    // Beats enter at the top, first beat ends in low word
    always_ff @(posedge clk_i)
    begin
        if (dfi_rddata_valid_i)
            line_q <= {dfi_rddata_i, line_q[LINE_W-1:DDR_DATA_W]};
    end

    // Beat count wraps every burst
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            beat_idx_q <= '0;
        else if (dfi_rddata_valid_i)
            beat_idx_q <= beat_idx_q + BEAT_W'(1);
    end

    // One cycle pulse after the last beat
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            valid_q <= 1'b0;
        else
            valid_q <= dfi_rddata_valid_i && (beat_idx_q == BEAT_W'(DDR_BURST_LEN - 1));
    end

    assign rddata_o       = line_q;
    assign rddata_valid_o = valid_q;

endmodule

// ==== design/dfi_seq_pkg.sv ====
//----------------------------------------
// DFI command sequencer shared definitions
// DDR geometry, latencies, derived timing,
// command codes and payload types
//----------------------------------------

package dfi_seq_pkg;

    //----------------------------------------
    // Geometry and latency
    //----------------------------------------
    localparam int DDR_MHZ           = 50;
    localparam int DDR_WRITE_LATENCY = 6;
    localparam int DDR_READ_LATENCY  = 5;
    localparam int DDR_BURST_LEN     = 4;
    localparam int DDR_ROW_W         = 15;
    localparam int DDR_BANK_W        = 3;
    localparam int DDR_DATA_W        = 32;
    localparam int DDR_DQM_W         = 4;

    // Host side word, one full burst
    localparam int LINE_W      = DDR_DATA_W * DDR_BURST_LEN;
    localparam int LINE_MASK_W = DDR_DQM_W * DDR_BURST_LEN;

    // Beat index width within a burst
    localparam int BEAT_W = $clog2(DDR_BURST_LEN);

    // PHY side latency, one cycle goes to the output flop
    localparam int PHY_WRLAT  = DDR_WRITE_LATENCY - 1;
    localparam int PHY_RDLAT  = DDR_READ_LATENCY - 1;
    localparam int WR_SHIFT_W = PHY_WRLAT + DDR_BURST_LEN;
    localparam int RD_SHIFT_W = PHY_RDLAT + DDR_BURST_LEN;

    //----------------------------------------
    // Derived timing counts
    //----------------------------------------
    // Clock period in ns, counts round up
    localparam int CYCLE_TIME_NS = 1000 / DDR_MHZ;
    localparam int DELAY_W       = 6;

    // ACTIVE to READ/WRITE, 15 ns
    localparam logic [DELAY_W-1:0] TRCD_CYCLES =
        DELAY_W'((15 + CYCLE_TIME_NS - 1) / CYCLE_TIME_NS);
    // PRECHARGE to ACTIVE, 15 ns
    localparam logic [DELAY_W-1:0] TRP_CYCLES =
        DELAY_W'((15 + CYCLE_TIME_NS - 1) / CYCLE_TIME_NS);
    // REFRESH cycle time, 260 ns
    localparam logic [DELAY_W-1:0] TRFC_CYCLES =
        DELAY_W'((260 + CYCLE_TIME_NS - 1) / CYCLE_TIME_NS);
    // Write to read turnaround
    localparam logic [DELAY_W-1:0] TWTR_CYCLES = DELAY_W'(5 + 1);

    // Spacing after READ or WRITE when direction may change
    localparam logic [DELAY_W-1:0] RW_NONSEQ_CYCLES =
        DELAY_W'(DDR_WRITE_LATENCY + DDR_BURST_LEN) + TWTR_CYCLES;
    // Counter value where a same direction command may follow
    localparam logic [DELAY_W-1:0] RW_SEQ_CYCLES =
        RW_NONSEQ_CYCLES + DELAY_W'(1) - DELAY_W'(DDR_BURST_LEN);

    //----------------------------------------
    // Types and command codes
    //----------------------------------------
    // Bits in order: cs_n, ras_n, cas_n, we_n
    typedef logic [3:0] ddr_cmd_t;

    localparam ddr_cmd_t CMD_NOP       = 4'b0111;
    localparam ddr_cmd_t CMD_ACTIVE    = 4'b0011;
    localparam ddr_cmd_t CMD_READ      = 4'b0101;
    localparam ddr_cmd_t CMD_WRITE     = 4'b0100;
    localparam ddr_cmd_t CMD_ZQCL      = 4'b0110;
    localparam ddr_cmd_t CMD_PRECHARGE = 4'b0010;
    localparam ddr_cmd_t CMD_REFRESH   = 4'b0001;
    localparam ddr_cmd_t CMD_LOAD_MODE = 4'b0000;

    typedef logic [DDR_ROW_W-1:0]   ddr_addr_t;
    typedef logic [DDR_BANK_W-1:0]  ddr_bank_t;
    typedef logic [DDR_DATA_W-1:0]  dfi_data_t;
    typedef logic [DDR_DQM_W-1:0]   dfi_mask_t;
    typedef logic [LINE_W-1:0]      line_data_t;
    typedef logic [LINE_MASK_W-1:0] line_mask_t;

    // Write queue payload, mask above data
    typedef struct packed {
        line_mask_t mask;
        line_data_t data;
    } wr_entry_t;

endpackage

// ==== design/dfi_seq_top.sv ====
//----------------------------------------
// DFI command sequencer top level
// Scheduler, write queue and data paths
//----------------------------------------
`timescale 1ns/1ns

module dfi_seq_top
    import dfi_seq_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  ddr_cmd_t   command_i,
    input  ddr_addr_t  address_i,
    input  ddr_bank_t  bank_i,
    input  logic       cke_i,
    input  line_data_t wrdata_i,
    input  line_mask_t wrdata_mask_i,
    input  dfi_data_t  dfi_rddata_i,
    input  logic       dfi_rddata_valid_i,
    output logic       accept_o,
    output line_data_t rddata_o,
    output logic       rddata_valid_o,
    output ddr_addr_t  dfi_address_o,
    output ddr_bank_t  dfi_bank_o,
    output logic       dfi_cas_n_o,
    output logic       dfi_cke_o,
    output logic       dfi_cs_n_o,
    output logic       dfi_odt_o,
    output logic       dfi_ras_n_o,
    output logic       dfi_reset_n_o,
    output logic       dfi_we_n_o,
    output dfi_data_t  dfi_wrdata_o,
    output logic       dfi_wrdata_en_o,
    output dfi_mask_t  dfi_wrdata_mask_o,
    output logic       dfi_rddata_en_o
);

    logic      wr_push_w;
    logic      wr_en_w;
    logic      wr_pop_w;
    wr_entry_t wr_in_w;
    wr_entry_t wr_head_w;

    // Line and mask sampled with the accepted WRITE
    assign wr_in_w.mask = wrdata_mask_i;
    assign wr_in_w.data = wrdata_i;

    // No on-die termination, PHY out of reset
    assign dfi_odt_o     = 1'b0;
    assign dfi_reset_n_o = 1'b1;

    dfi_cmd_sched u_sched (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .command_i       (command_i),
        .address_i       (address_i),
        .bank_i          (bank_i),
        .cke_i           (cke_i),
        .accept_o        (accept_o),
        .wr_push_o       (wr_push_w),
        .wr_en_o         (wr_en_w),
        .dfi_rddata_en_o (dfi_rddata_en_o),
        .dfi_cs_n_o      (dfi_cs_n_o),
        .dfi_ras_n_o     (dfi_ras_n_o),
        .dfi_cas_n_o     (dfi_cas_n_o),
        .dfi_we_n_o      (dfi_we_n_o),
        .dfi_address_o   (dfi_address_o),
        .dfi_bank_o      (dfi_bank_o),
        .dfi_cke_o       (dfi_cke_o)
    );

    dfi_wr_fifo #(
        .DEPTH (4)
    ) u_wr_fifo (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .push_i (wr_push_w),
        .data_i (wr_in_w),
        .pop_i  (wr_pop_w),
        .data_o (wr_head_w)
    );

    dfi_wr_serializer u_wr_ser (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .wr_en_i           (wr_en_w),
        .entry_i           (wr_head_w),
        .pop_o             (wr_pop_w),
        .dfi_wrdata_o      (dfi_wrdata_o),
        .dfi_wrdata_mask_o (dfi_wrdata_mask_o),
        .dfi_wrdata_en_o   (dfi_wrdata_en_o)
    );

    dfi_rd_assembler u_rd_asm (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .dfi_rddata_i       (dfi_rddata_i),
        .dfi_rddata_valid_i (dfi_rddata_valid_i),
        .rddata_o           (rddata_o),
        .rddata_valid_o     (rddata_valid_o)
    );

endmodule

// ==== design/dfi_wr_fifo.sv ====
//----------------------------------------
// Write data queue
// Holds write lines and masks until burst
//----------------------------------------
`timescale 1ns/1ns

module dfi_wr_fifo
    import dfi_seq_pkg::*;
#(
    parameter int DEPTH = 4
)
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      push_i,
    input  wr_entry_t data_i,
    input  logic      pop_i,
    output wr_entry_t data_o
);

    localparam int ADDR_W  = $clog2(DEPTH);
    localparam int COUNT_W = ADDR_W + 1;

    wr_entry_t          mem_q [DEPTH];
    logic [ADDR_W-1:0]  rd_ptr_q;
    logic [ADDR_W-1:0]  wr_ptr_q;
    logic [COUNT_W-1:0] count_q;
    logic               do_push_w;
    logic               do_pop_w;

    // Drop push when full, pop when empty
    assign do_push_w = push_i && (count_q != COUNT_W'(DEPTH));
    assign do_pop_w  = pop_i && (count_q != '0);

    // Storage
    always_ff @(posedge clk_i)
    begin
        if (do_push_w)
            mem_q[wr_ptr_q] <= data_i;
    end

    // Pointers wrap on power of two depth
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push_w)
                wr_ptr_q <= wr_ptr_q + ADDR_W'(1);
            if (do_pop_w)
                rd_ptr_q <= rd_ptr_q + ADDR_W'(1);
            if (do_push_w && !do_pop_w)
                count_q <= count_q + COUNT_W'(1);
            else if (!do_push_w && do_pop_w)
                count_q <= count_q - COUNT_W'(1);
        end
    end

    // Head entry, always visible
    assign data_o = mem_q[rd_ptr_q];

endmodule

// ==== design/dfi_wr_serializer.sv ====
//----------------------------------------
// Write beat serializer
// Splits a queued line into four DFI beats
//----------------------------------------
`timescale 1ns/1ns

module dfi_wr_serializer
    import dfi_seq_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      wr_en_i,
    input  wr_entry_t entry_i,
    output logic      pop_o,
    output dfi_data_t dfi_wrdata_o,
    output dfi_mask_t dfi_wrdata_mask_o,
    output logic      dfi_wrdata_en_o
);

    logic [BEAT_W-1:0] beat_idx_q;
    dfi_data_t         wrdata_q;
    dfi_mask_t         wrmask_q;
    logic              wrdata_en_q;
    dfi_data_t         beat_data_w;
    dfi_mask_t         beat_mask_w;

    //----------------------------------------
    // Beat select
    //----------------------------------------
    // Low word and low nibble go first
    assign beat_data_w = entry_i.data[beat_idx_q * DDR_DATA_W +: DDR_DATA_W];
    assign beat_mask_w = entry_i.mask[beat_idx_q * DDR_DQM_W +: DDR_DQM_W];

    // Head is done after the last beat
    assign pop_o = wr_en_i && (beat_idx_q == BEAT_W'(DDR_BURST_LEN - 1));

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            beat_idx_q <= '0;
        else if (wr_en_i)
            beat_idx_q <= beat_idx_q + BEAT_W'(1);
    end

    //----------------------------------------
    // Output flops
    //----------------------------------------
    // Idle bus shows zero data, all bytes masked
    always_ff @(posedge clk_i)
    begin
        if (rst_i || !wr_en_i)
        begin
            wrdata_q <= '0;
            wrmask_q <= '1;
        end
        else
        begin
            wrdata_q <= beat_data_w;
            wrmask_q <= beat_mask_w;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            wrdata_en_q <= 1'b0;
        else
            wrdata_en_q <= wr_en_i;
    end

    assign dfi_wrdata_o      = wrdata_q;
    assign dfi_wrdata_mask_o = wrmask_q;
    assign dfi_wrdata_en_o   = wrdata_en_q;

endmodule

// ==== sim/tb_dfi_seq.sv ====
//----------------------------------------
// DFI command sequencer testbench
// Directed tests on command, write and
// read paths with a closing report
//----------------------------------------
`timescale 1ns/1ns

module tb_dfi_seq
    import dfi_seq_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 64;
    localparam int IDLE_GAP     = 24;
    localparam int RUN_LIMIT_NS = 100000;

    // Stall seen by a same direction follow-up
    localparam int SEQ_STALL = int'(RW_NONSEQ_CYCLES - RW_SEQ_CYCLES);

    logic       clk_i;
    logic       rst_i;
    ddr_cmd_t   command_i;
    ddr_addr_t  address_i;
    ddr_bank_t  bank_i;
    logic       cke_i;
    line_data_t wrdata_i;
    line_mask_t wrdata_mask_i;
    dfi_data_t  dfi_rddata_i;
    logic       dfi_rddata_valid_i;
    logic       accept_o;
    line_data_t rddata_o;
    logic       rddata_valid_o;
    ddr_addr_t  dfi_address_o;
    ddr_bank_t  dfi_bank_o;
    logic       dfi_cas_n_o;
    logic       dfi_cke_o;
    logic       dfi_cs_n_o;
    logic       dfi_odt_o;
    logic       dfi_ras_n_o;
    logic       dfi_reset_n_o;
    logic       dfi_we_n_o;
    dfi_data_t  dfi_wrdata_o;
    logic       dfi_wrdata_en_o;
    dfi_mask_t  dfi_wrdata_mask_o;
    logic       dfi_rddata_en_o;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lcg_state = 32'd15787;

    dfi_seq_top uut (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .command_i          (command_i),
        .address_i          (address_i),
        .bank_i             (bank_i),
        .cke_i              (cke_i),
        .wrdata_i           (wrdata_i),
        .wrdata_mask_i      (wrdata_mask_i),
        .dfi_rddata_i       (dfi_rddata_i),
        .dfi_rddata_valid_i (dfi_rddata_valid_i),
        .accept_o           (accept_o),
        .rddata_o           (rddata_o),
        .rddata_valid_o     (rddata_valid_o),
        .dfi_address_o      (dfi_address_o),
        .dfi_bank_o         (dfi_bank_o),
        .dfi_cas_n_o        (dfi_cas_n_o),
        .dfi_cke_o          (dfi_cke_o),
        .dfi_cs_n_o         (dfi_cs_n_o),
        .dfi_odt_o          (dfi_odt_o),
        .dfi_ras_n_o        (dfi_ras_n_o),
        .dfi_reset_n_o      (dfi_reset_n_o),
        .dfi_we_n_o         (dfi_we_n_o),
        .dfi_wrdata_o       (dfi_wrdata_o),
        .dfi_wrdata_en_o    (dfi_wrdata_en_o),
        .dfi_wrdata_mask_o  (dfi_wrdata_mask_o),
        .dfi_rddata_en_o    (dfi_rddata_en_o)
    );

    // 20 ns clock
    initial
    begin
        clk_i = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    //----------------------------------------
    // Random data
    //----------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic line_data_t rand_line();
        line_data_t v;
        int         k;
        for (k = 0; k < DDR_BURST_LEN; k++)
            v[k*DDR_DATA_W +: DDR_DATA_W] = lcg_next();
        return v;
    endfunction

    //----------------------------------------
    // Compare tasks
    //----------------------------------------
    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cmd(input string name, input ddr_cmd_t got, input ddr_cmd_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input ddr_addr_t got, input ddr_addr_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bank(input string name, input ddr_bank_t got, input ddr_bank_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input dfi_data_t got, input dfi_data_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input dfi_mask_t got, input dfi_mask_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_line(input string name, input line_data_t got,
                              input line_data_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Cycle counts, latencies and stalls
    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Pins in order cs_n, ras_n, cas_n, we_n
    task automatic check_dfi_cmd(input ddr_cmd_t cmd, input ddr_addr_t addr,
                                 input ddr_bank_t bank);
        check_cmd("dfi command pins", {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o},
                  cmd);
        check_addr("dfi_address_o", dfi_address_o, addr);
        check_bank("dfi_bank_o", dfi_bank_o, bank);
    endtask

    //----------------------------------------
    // Stimulus helpers
    //----------------------------------------
    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic drive_cmd(input ddr_cmd_t cmd, input ddr_addr_t addr,
                             input ddr_bank_t bank);
        command_i = cmd;
        address_i = addr;
        bank_i    = bank;
    endtask

    task automatic idle_cycles(input int n);
        drive_cmd(CMD_NOP, '0, '0);
        repeat (n)
            next_cycle();
    endtask

    // Counts cycles with accept low, sampled at the falling edge
    task automatic wait_accept(input string what, output int low_cycles);
        low_cycles = 0;
        @(negedge clk_i);
        while (!accept_o && low_cycles < WAIT_LIMIT)
        begin
            low_cycles++;
            @(negedge clk_i);
        end
        if (!accept_o)
        begin
            $display("Timeout: %s was never accepted", what);
            errors++;
        end
    endtask

    // Ends one cycle after the accepting edge with NOP driven
    task automatic send_cmd(input string what, input ddr_cmd_t cmd, input ddr_addr_t addr,
                            input ddr_bank_t bank, output int low_cycles);
        drive_cmd(cmd, addr, bank);
        wait_accept(what, low_cycles);
        next_cycle();
        drive_cmd(CMD_NOP, '0, '0);
    endtask

    // Idle bus until the burst, then beat k is word k and nibble k
    task automatic collect_write_burst(input line_data_t line, input line_mask_t mask,
                                       output int waited);
        int k;
        waited = 0;
        @(negedge clk_i);
        while (!dfi_wrdata_en_o && waited < WAIT_LIMIT)
        begin
            check_data("dfi_wrdata_o idle", dfi_wrdata_o, '0);
            check_mask("dfi_wrdata_mask_o idle", dfi_wrdata_mask_o, '1);
            waited++;
            @(negedge clk_i);
        end
        if (!dfi_wrdata_en_o)
        begin
            $display("Timeout: write burst never started");
            errors++;
        end
        else
        begin
            for (k = 0; k < DDR_BURST_LEN; k++)
            begin
                if (k > 0)
                    @(negedge clk_i);
                check_bit("dfi_wrdata_en_o", dfi_wrdata_en_o, 1'b1);
                check_data("dfi_wrdata_o", dfi_wrdata_o, line[k*DDR_DATA_W +: DDR_DATA_W]);
                check_mask("dfi_wrdata_mask_o", dfi_wrdata_mask_o,
                           mask[k*DDR_DQM_W +: DDR_DQM_W]);
            end
        end
    endtask

    task automatic check_write_idle();
        @(negedge clk_i);
        check_bit("dfi_wrdata_en_o after burst", dfi_wrdata_en_o, 1'b0);
        check_data("dfi_wrdata_o after burst", dfi_wrdata_o, '0);
        check_mask("dfi_wrdata_mask_o after burst", dfi_wrdata_mask_o, '1);
    endtask

    //----------------------------------------
    // Tests
    //----------------------------------------
    task automatic test_reset();
        @(negedge clk_i);
        check_dfi_cmd(CMD_NOP, '0, '0);
        check_bit("accept_o for NOP", accept_o, 1'b1);
        check_bit("dfi_wrdata_en_o", dfi_wrdata_en_o, 1'b0);
        check_bit("dfi_rddata_en_o", dfi_rddata_en_o, 1'b0);
        check_bit("rddata_valid_o", rddata_valid_o, 1'b0);
        check_bit("dfi_cke_o", dfi_cke_o, 1'b0);
        check_bit("dfi_odt_o", dfi_odt_o, 1'b0);
        check_bit("dfi_reset_n_o", dfi_reset_n_o, 1'b1);
        // CKE one cycle behind
        next_cycle();
        cke_i = 1'b1;
        @(negedge clk_i);
        check_bit("dfi_cke_o same cycle", dfi_cke_o, 1'b0);
        next_cycle();
        @(negedge clk_i);
        check_bit("dfi_cke_o next cycle", dfi_cke_o, 1'b1);
        next_cycle();
    endtask

    task automatic test_cmd_drive();
        ddr_addr_t addr;
        ddr_bank_t bank;
        int        low;
        addr = ddr_addr_t'(lcg_next());
        bank = ddr_bank_t'(lcg_next());
        send_cmd("ACTIVE", CMD_ACTIVE, addr, bank, low);
        check_count("ACTIVE stall from idle", low, 0);
        @(negedge clk_i);
        check_dfi_cmd(CMD_ACTIVE, addr, bank);
        next_cycle();
        @(negedge clk_i);
        check_dfi_cmd(CMD_NOP, '0, '0);
        idle_cycles(IDLE_GAP);
    endtask

    task automatic test_cmd_spacing();
        int low;
        send_cmd("REFRESH", CMD_REFRESH, '0, '0, low);
        // PRECHARGE held from the first cycle after REFRESH
        drive_cmd(CMD_PRECHARGE, '0, ddr_bank_t'(1));
        wait_accept("PRECHARGE after REFRESH", low);
        check_count("PRECHARGE stall after REFRESH", low, int'(TRFC_CYCLES));
        next_cycle();
        idle_cycles(IDLE_GAP);
        send_cmd("ACTIVE", CMD_ACTIVE, ddr_addr_t'(lcg_next()), ddr_bank_t'(2), low);
        drive_cmd(CMD_PRECHARGE, '0, ddr_bank_t'(2));
        wait_accept("PRECHARGE after ACTIVE", low);
        check_count("PRECHARGE stall after ACTIVE", low, int'(TRCD_CYCLES));
        next_cycle();
        idle_cycles(IDLE_GAP);
    endtask

    task automatic test_write_burst();
        line_data_t d0;
        line_data_t d1;
        line_data_t d2;
        line_mask_t m0;
        line_mask_t m1;
        line_mask_t m2;
        int         low;
        int         waited;
        d0 = rand_line();
        m0 = line_mask_t'(lcg_next());
        wrdata_i      = d0;
        wrdata_mask_i = m0;
        send_cmd("WRITE", CMD_WRITE, ddr_addr_t'(lcg_next()), '0, low);
        wrdata_i      = '0;
        wrdata_mask_i = '0;
        collect_write_burst(d0, m0, waited);
        check_count("write latency", waited, DDR_WRITE_LATENCY);
        check_write_idle();
        next_cycle();
        idle_cycles(IDLE_GAP);

        // Two writes back to back
        d1 = rand_line();
        m1 = line_mask_t'(lcg_next());
        d2 = rand_line();
        m2 = line_mask_t'(lcg_next());
        wrdata_i      = d1;
        wrdata_mask_i = m1;
        send_cmd("first WRITE", CMD_WRITE, ddr_addr_t'(lcg_next()), '0, low);
        wrdata_i      = d2;
        wrdata_mask_i = m2;
        send_cmd("second WRITE", CMD_WRITE, ddr_addr_t'(lcg_next()), '0, low);
        check_count("same direction WRITE stall", low, SEQ_STALL);
        wrdata_i      = '0;
        wrdata_mask_i = '0;
        collect_write_burst(d1, m1, waited);
        check_count("first burst wait", waited, DDR_WRITE_LATENCY - SEQ_STALL - 1);
        collect_write_burst(d2, m2, waited);
        check_count("gap between bursts", waited, 0);
        check_write_idle();
        next_cycle();
        idle_cycles(IDLE_GAP);
    endtask

    task automatic test_read_path();
        dfi_data_t  beats [DDR_BURST_LEN];
        line_data_t exp_line;
        int         low;
        int         n;
        int         k;
        send_cmd("READ", CMD_READ, ddr_addr_t'(lcg_next()), '0, low);
        n = 0;
        @(negedge clk_i);
        while (!dfi_rddata_en_o && n < WAIT_LIMIT)
        begin
            n++;
            @(negedge clk_i);
        end
        if (!dfi_rddata_en_o)
        begin
            $display("Timeout: dfi_rddata_en_o never rose");
            errors++;
        end
        else
        begin
            check_count("read latency", n, DDR_READ_LATENCY);
            for (k = 1; k < DDR_BURST_LEN; k++)
            begin
                @(negedge clk_i);
                check_bit("dfi_rddata_en_o in burst", dfi_rddata_en_o, 1'b1);
            end
            @(negedge clk_i);
            check_bit("dfi_rddata_en_o after burst", dfi_rddata_en_o, 1'b0);
        end

        // Return four beats, first beat lands in the low word
        for (k = 0; k < DDR_BURST_LEN; k++)
        begin
            beats[k] = lcg_next();
            exp_line[k*DDR_DATA_W +: DDR_DATA_W] = beats[k];
        end
        for (k = 0; k < DDR_BURST_LEN; k++)
        begin
            next_cycle();
            dfi_rddata_valid_i = 1'b1;
            dfi_rddata_i       = beats[k];
        end
        next_cycle();
        dfi_rddata_valid_i = 1'b0;
        dfi_rddata_i       = '0;
        n = 0;
        @(negedge clk_i);
        while (!rddata_valid_o && n < WAIT_LIMIT)
        begin
            n++;
            @(negedge clk_i);
        end
        if (!rddata_valid_o)
        begin
            $display("Timeout: rddata_valid_o never pulsed");
            errors++;
        end
        else
        begin
            check_count("read valid delay", n, 0);
            check_line("rddata_o", rddata_o, exp_line);
            @(negedge clk_i);
            check_bit("rddata_valid_o pulse end", rddata_valid_o, 1'b0);
        end
        next_cycle();
        idle_cycles(IDLE_GAP);
    endtask

    task automatic test_dir_change();
        line_data_t d;
        line_mask_t m;
        int         low;
        int         waited;
        d = rand_line();
        m = line_mask_t'(lcg_next());
        send_cmd("READ", CMD_READ, ddr_addr_t'(lcg_next()), '0, low);
        wrdata_i      = d;
        wrdata_mask_i = m;
        // No early accept across a direction change
        send_cmd("WRITE after READ", CMD_WRITE, ddr_addr_t'(lcg_next()), '0, low);
        check_count("WRITE stall after READ", low, int'(RW_NONSEQ_CYCLES));
        wrdata_i      = '0;
        wrdata_mask_i = '0;
        collect_write_burst(d, m, waited);
        check_count("write latency after READ", waited, DDR_WRITE_LATENCY);
        check_write_idle();
        next_cycle();
        idle_cycles(IDLE_GAP);
    endtask

    //----------------------------------------
    // Main sequence
    //----------------------------------------
    initial
    begin
        rst_i              = 1'b1;
        command_i          = CMD_NOP;
        address_i          = '0;
        bank_i             = '0;
        cke_i              = 1'b0;
        wrdata_i           = '0;
        wrdata_mask_i      = '0;
        dfi_rddata_i       = '0;
        dfi_rddata_valid_i = 1'b0;
        repeat (RESET_CYCLES)
            @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        test_reset();
        test_cmd_drive();
        test_cmd_spacing();
        test_write_burst();
        test_read_path();
        test_dir_change();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Overall run limit
    initial
    begin
        #(RUN_LIMIT_NS);
        $display("Timeout: simulation ran past its time limit");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== src.f ====
design/dfi_seq_pkg.sv
design/dfi_cmd_sched.sv
design/dfi_wr_fifo.sv
design/dfi_wr_serializer.sv
design/dfi_rd_assembler.sv
design/dfi_seq_top.sv
sim/tb_dfi_seq.sv
